/* common/commit_cfg.svh */
`ifndef COMMIT_CFG_SVH
`define COMMIT_CFG_SVH

// Datapath and PC width
`define XLEN 32

// Reorder buffer geometry
`define ROB_DEPTH 8
`define ROB_IDX_W 3

// Architectural register index
`define REG_IDX_W 5

// Exception causes
`define EXC_CODE_W 4
// Cause value reserved for a resolved misprediction, not a real trap
`define EXC_MISPREDICT 4'hE

`endif

/* common/commit_pkg.sv */
`include "commit_cfg.svh"

package commit_pkg;

  // --------------------------------------------------------------------------
  // Basic vectors
  // --------------------------------------------------------------------------
  typedef logic [`XLEN-1:0]       xlen_t;
  typedef logic [`ROB_IDX_W-1:0]  rob_idx_t;
  typedef logic [`REG_IDX_W-1:0]  reg_idx_t;
  typedef logic [`EXC_CODE_W-1:0] exc_code_t;

  // --------------------------------------------------------------------------
  // Structures
  // --------------------------------------------------------------------------

  // Written by issue into a fresh entry
  typedef struct packed {
    xlen_t    instr_pc;
    reg_idx_t rd_idx;
    logic     jb_instr;
  } issue_entry_t;

  typedef struct packed {
    issue_entry_t info;
    xlen_t        res_value;
    logic         res_ready;
    logic         except_raised;
    exc_code_t    except_code;
  } rob_entry_t;

  // One result broadcast
  typedef struct packed {
    rob_idx_t  rob_idx;
    xlen_t     res_value;
    logic      except_raised;
    exc_code_t except_code;
  } cdb_data_t;

  // Instruction being committed, tagged with its old ROB slot
  typedef struct packed {
    rob_entry_t entry;
    rob_idx_t   rob_idx;
  } slot_t;

  typedef struct packed {
    logic  ready;
    xlen_t value;
  } operand_t;

  // mtvec as seen by commit, mode 1 means vectored
  typedef struct packed {
    logic [`XLEN-3:0] base;
    logic             mode;
  } mtvec_t;

  typedef enum logic [1:0] {
    IDLE,
    COMMIT,
    MISPREDICT,
    EXCEPT
  } commit_state_t;

endpackage

/* rob/rob.sv */
`timescale 1ns/1ps

`include "commit_cfg.svh"

module rob import commit_pkg::*; #(
  parameter int DEPTH = `ROB_DEPTH
) (
  input  logic         clk_i,
  input  logic         rst_n_i,
  input  logic         flush_i,

  // Issue side
  input  logic         issue_valid_i,
  output logic         issue_ready_o,
  input  issue_entry_t issue_data_i,
  output rob_idx_t     issue_tail_idx_o,

  // Result writeback
  input  logic         cdb_valid_i,
  input  cdb_data_t    cdb_data_i,

  // Head towards commit
  output logic         head_valid_o,
  output rob_entry_t   head_entry_o,
  output rob_idx_t     head_idx_o,
  input  logic         pop_i,

  // Operand lookup
  input  rob_idx_t     rs1_idx_i,
  input  rob_idx_t     rs2_idx_i,
  output logic         rs1_hit_o,
  output logic         rs2_hit_o,
  output operand_t     rs1_opnd_o,
  output operand_t     rs2_opnd_o
);

  localparam int IDX_W = $clog2(DEPTH);

  logic [IDX_W-1:0] head_q;
  logic [IDX_W-1:0] tail_q;
  logic [IDX_W:0]   count_q;
  logic [DEPTH-1:0] valid_q;
  rob_entry_t       entries_q [DEPTH];

  logic             issue_fire;
  logic [IDX_W-1:0] cdb_ptr;
  logic [IDX_W-1:0] rs1_ptr;
  logic [IDX_W-1:0] rs2_ptr;

  assign issue_ready_o = (count_q != (IDX_W+1)'(DEPTH));
  assign issue_fire    = issue_valid_i & issue_ready_o;

  assign cdb_ptr = IDX_W'(cdb_data_i.rob_idx);
  assign rs1_ptr = IDX_W'(rs1_idx_i);
  assign rs2_ptr = IDX_W'(rs2_idx_i);

  // --------------------------------------------------------------------------
  // Pointers, occupancy and per-entry valid bits
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
    end else if (flush_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      valid_q <= '0;
    end else begin
      if (issue_fire) begin
        tail_q          <= tail_q + 1'b1;
        valid_q[tail_q] <= 1'b1;
      end
      if (pop_i) begin
        head_q          <= head_q + 1'b1;
        valid_q[head_q] <= 1'b0;
      end
      // Simultaneous issue and pop leave the count unchanged
      case ({issue_fire, pop_i})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // --------------------------------------------------------------------------
  // Entry storage
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (issue_fire) begin
      entries_q[tail_q].info          <= issue_data_i;
      entries_q[tail_q].res_ready     <= 1'b0;
      entries_q[tail_q].except_raised <= 1'b0;
      entries_q[tail_q].except_code   <= '0;
    end
    // Writeback never hits the slot being allocated
    if (cdb_valid_i) begin
      entries_q[cdb_ptr].res_value     <= cdb_data_i.res_value;
      entries_q[cdb_ptr].res_ready     <= 1'b1;
      entries_q[cdb_ptr].except_raised <= cdb_data_i.except_raised;
      entries_q[cdb_ptr].except_code   <= cdb_data_i.except_code;
    end
  end

  assign issue_tail_idx_o = rob_idx_t'(tail_q);

  assign head_valid_o = valid_q[head_q];
  assign head_entry_o = entries_q[head_q];
  assign head_idx_o   = rob_idx_t'(head_q);

  // Lookup on occupied slots only
  assign rs1_hit_o        = valid_q[rs1_ptr];
  assign rs1_opnd_o.ready = entries_q[rs1_ptr].res_ready;
  assign rs1_opnd_o.value = entries_q[rs1_ptr].res_value;

  assign rs2_hit_o        = valid_q[rs2_ptr];
  assign rs2_opnd_o.ready = entries_q[rs2_ptr].res_ready;
  assign rs2_opnd_o.value = entries_q[rs2_ptr].res_value;

endmodule

/* source/commit_fsm.sv */
`timescale 1ns/1ps

`include "commit_cfg.svh"

module commit_fsm import commit_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,

  input  logic       head_valid_i,
  input  rob_entry_t head_entry_i,
  input  logic       fe_ready_i,

  output logic       pop_o,
  output logic       int_rf_valid_o,
  output logic       jb_commit_o,
  output logic       mis_flush_o,
  output logic       except_flush_o,
  output logic       fe_except_raised_o
);

  commit_state_t state_q;
  commit_state_t state_d;

  logic head_ready;
  logic head_mispredict;
  logic can_pop;

  assign head_ready      = head_valid_i & head_entry_i.res_ready;
  assign head_mispredict = (head_entry_i.except_code == `EXC_MISPREDICT);

  // Only idle and plain commit cycles may take a new head
  assign can_pop     = (state_q == IDLE) || (state_q == COMMIT);
  assign pop_o       = can_pop & head_ready;
  assign jb_commit_o = pop_o & head_entry_i.info.jb_instr;

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE, COMMIT: begin
        if (!head_ready) begin
          state_d = IDLE;
        end else if (head_mispredict) begin
          state_d = MISPREDICT;
        end else if (head_entry_i.except_raised) begin
          state_d = EXCEPT;
        end else begin
          state_d = COMMIT;
        end
      end
      MISPREDICT: state_d = IDLE;
      // Wait for the front end to accept the trap
      EXCEPT: begin
        if (fe_ready_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Outputs depend on state only
  assign int_rf_valid_o     = (state_q == COMMIT) || (state_q == MISPREDICT);
  assign mis_flush_o        = (state_q == MISPREDICT);
  assign except_flush_o     = (state_q == EXCEPT);
  assign fe_except_raised_o = (state_q == EXCEPT);

endmodule

/* source/jb_counter.sv */
`timescale 1ns/1ps

`include "commit_cfg.svh"

module jb_counter import commit_pkg::*; (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic issue_jb_i,
  input  logic commit_jb_i,
  input  logic clr_i,
  output logic spec_o
);

  // One extra bit so a completely full ROB of branches fits
  logic [`ROB_IDX_W:0] cnt_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (clr_i) begin
      cnt_q <= '0;
    end else if (issue_jb_i && !commit_jb_i) begin
      cnt_q <= cnt_q + 1'b1;
    end else if (commit_jb_i && !issue_jb_i) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign spec_o = |cnt_q;

endmodule

/* source/commit_slot.sv */
`timescale 1ns/1ps

`include "commit_cfg.svh"

module commit_slot import commit_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,

  input  logic     load_i,
  input  logic     clr_i,
  input  slot_t    head_i,
  input  mtvec_t   mtvec_i,

  output slot_t    slot_o,
  output logic     slot_valid_o,
  output reg_idx_t rd_idx_o,
  output xlen_t    rd_value_o,
  output xlen_t    fe_except_pc_o
);

  slot_t slot_q;
  logic  valid_q;
  xlen_t trap_base;
  xlen_t trap_offset;

  // --------------------------------------------------------------------------
  // Committing instruction register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (clr_i) begin
      valid_q <= 1'b0;
    end else begin
      // Valid only in the cycle right after a pop
      valid_q <= load_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_i) begin
      slot_q <= head_i;
    end
  end

  // --------------------------------------------------------------------------
  // Trap vector
  // --------------------------------------------------------------------------
  assign trap_base = {mtvec_i.base, 2'b00};

  // Vectored mode jumps to base + 4 * cause
  assign trap_offset = mtvec_i.mode ?
      {{(`XLEN-`EXC_CODE_W-2){1'b0}}, slot_q.entry.except_code, 2'b00} : '0;

  assign fe_except_pc_o = trap_base + trap_offset;

  assign slot_o       = slot_q;
  assign slot_valid_o = valid_q;
  assign rd_idx_o     = slot_q.entry.info.rd_idx;
  assign rd_value_o   = slot_q.entry.res_value;

endmodule

/* source/operand_fwd.sv */
`timescale 1ns/1ps

module operand_fwd import commit_pkg::*; (
  input  logic      cdb_valid_i,
  input  cdb_data_t cdb_data_i,

  input  rob_idx_t  rs1_idx_i,
  input  rob_idx_t  rs2_idx_i,

  input  logic      rs1_hit_i,
  input  operand_t  rs1_rob_i,
  input  logic      rs2_hit_i,
  input  operand_t  rs2_rob_i,

  input  slot_t     slot_i,
  input  logic      slot_valid_i,

  output operand_t  rs1_o,
  output operand_t  rs2_o
);

  // Newest source first: CDB, then ROB, then the committing slot
  function automatic operand_t pick(input rob_idx_t idx, input logic rob_hit,
                                    input operand_t rob_opnd);
    operand_t res;
    if (cdb_valid_i && (cdb_data_i.rob_idx == idx)) begin
      res.ready = 1'b1;
      res.value = cdb_data_i.res_value;
    end else if (rob_hit) begin
      res = rob_opnd;
    end else if (slot_valid_i && (slot_i.rob_idx == idx)) begin
      res.ready = 1'b1;
      res.value = slot_i.entry.res_value;
    end else begin
      res.ready = 1'b0;
      res.value = '0;
    end
    return res;
  endfunction

  always_comb begin
    rs1_o = pick(rs1_idx_i, rs1_hit_i, rs1_rob_i);
    rs2_o = pick(rs2_idx_i, rs2_hit_i, rs2_rob_i);
  end

endmodule

/* source/commit_stage.sv */
`timescale 1ns/1ps

`include "commit_cfg.svh"

module commit_stage import commit_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_n_i,

  // Issue logic
  input  logic         issue_valid_i,
  output logic         issue_ready_o,
  input  issue_entry_t issue_data_i,
  output rob_idx_t     issue_tail_idx_o,
  input  logic         issue_jb_instr_i,
  input  rob_idx_t     issue_rs1_idx_i,
  input  rob_idx_t     issue_rs2_idx_i,
  output operand_t     issue_rs1_o,
  output operand_t     issue_rs2_o,

  // Common data bus
  input  logic         cdb_valid_i,
  input  cdb_data_t    cdb_data_i,

  input  mtvec_t       mtvec_i,

  // Front end
  input  logic         fe_ready_i,
  output logic         fe_except_raised_o,
  output xlen_t        fe_except_pc_o,

  // Integer register file
  output logic         int_rf_valid_o,
  output reg_idx_t     rd_idx_o,
  output xlen_t        rd_value_o,

  output logic         ex_mis_flush_o,
  output logic         except_flush_o,
  output logic         sb_spec_instr_o
);

  logic       head_valid;
  rob_entry_t head_entry;
  rob_idx_t   head_idx;
  slot_t      head_slot;
  logic       pop;
  logic       jb_commit;
  logic       jb_issue;
  logic       flush;

  logic       rs1_hit;
  logic       rs2_hit;
  operand_t   rs1_rob;
  operand_t   rs2_rob;

  slot_t      slot;
  logic       slot_valid;

  // An exception flush lands only once the front end takes the trap
  assign flush    = ex_mis_flush_o | (except_flush_o & fe_ready_i);
  assign jb_issue = issue_valid_i & issue_ready_o & issue_jb_instr_i;

  assign head_slot = '{entry: head_entry, rob_idx: head_idx};

  // --------------------------------------------------------------------------
  // Reorder buffer and commit control
  // --------------------------------------------------------------------------
  rob #(
    .DEPTH(`ROB_DEPTH)
  ) u_rob (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .flush_i         (flush),
    .issue_valid_i   (issue_valid_i),
    .issue_ready_o   (issue_ready_o),
    .issue_data_i    (issue_data_i),
    .issue_tail_idx_o(issue_tail_idx_o),
    .cdb_valid_i     (cdb_valid_i),
    .cdb_data_i      (cdb_data_i),
    .head_valid_o    (head_valid),
    .head_entry_o    (head_entry),
    .head_idx_o      (head_idx),
    .pop_i           (pop),
    .rs1_idx_i       (issue_rs1_idx_i),
    .rs2_idx_i       (issue_rs2_idx_i),
    .rs1_hit_o       (rs1_hit),
    .rs2_hit_o       (rs2_hit),
    .rs1_opnd_o      (rs1_rob),
    .rs2_opnd_o      (rs2_rob)
  );

  commit_fsm u_commit_fsm (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .head_valid_i      (head_valid),
    .head_entry_i      (head_entry),
    .fe_ready_i        (fe_ready_i),
    .pop_o             (pop),
    .int_rf_valid_o    (int_rf_valid_o),
    .jb_commit_o       (jb_commit),
    .mis_flush_o       (ex_mis_flush_o),
    .except_flush_o    (except_flush_o),
    .fe_except_raised_o(fe_except_raised_o)
  );

  // --------------------------------------------------------------------------
  // Speculation tracking, commit register and forwarding
  // --------------------------------------------------------------------------
  jb_counter u_jb_counter (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .issue_jb_i (jb_issue),
    .commit_jb_i(jb_commit),
    .clr_i      (flush),
    .spec_o     (sb_spec_instr_o)
  );

  commit_slot u_commit_slot (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .load_i        (pop),
    .clr_i         (flush),
    .head_i        (head_slot),
    .mtvec_i       (mtvec_i),
    .slot_o        (slot),
    .slot_valid_o  (slot_valid),
    .rd_idx_o      (rd_idx_o),
    .rd_value_o    (rd_value_o),
    .fe_except_pc_o(fe_except_pc_o)
  );

  operand_fwd u_operand_fwd (
    .cdb_valid_i (cdb_valid_i),
    .cdb_data_i  (cdb_data_i),
    .rs1_idx_i   (issue_rs1_idx_i),
    .rs2_idx_i   (issue_rs2_idx_i),
    .rs1_hit_i   (rs1_hit),
    .rs1_rob_i   (rs1_rob),
    .rs2_hit_i   (rs2_hit),
    .rs2_rob_i   (rs2_rob),
    .slot_i      (slot),
    .slot_valid_i(slot_valid),
    .rs1_o       (issue_rs1_o),
    .rs2_o       (issue_rs2_o)
  );

endmodule

/* tests/tb_commit_stage.sv */
`timescale 1ns/1ps

`include "commit_cfg.svh"

module tb_commit_stage import commit_pkg::*; ();

  localparam int NUM_TESTS = 6;
  localparam int RST_CYCLES = 8;

  logic         clk_i;
  logic         rst_n_i;
  logic         issue_valid_i;
  logic         issue_ready_o;
  issue_entry_t issue_data_i;
  rob_idx_t     issue_tail_idx_o;
  logic         issue_jb_instr_i;
  rob_idx_t     issue_rs1_idx_i;
  rob_idx_t     issue_rs2_idx_i;
  operand_t     issue_rs1_o;
  operand_t     issue_rs2_o;
  logic         cdb_valid_i;
  cdb_data_t    cdb_data_i;
  mtvec_t       mtvec_i;
  logic         fe_ready_i;
  logic         fe_except_raised_o;
  xlen_t        fe_except_pc_o;
  logic         int_rf_valid_o;
  reg_idx_t     rd_idx_o;
  xlen_t        rd_value_o;
  logic         ex_mis_flush_o;
  logic         except_flush_o;
  logic         sb_spec_instr_o;

  // Reference model with one record per issued instruction
  reg_idx_t  m_rd   [256];
  xlen_t     m_val  [256];
  logic      m_jb   [256];
  logic      m_done [256];
  logic      m_exc  [256];
  logic      m_mis  [256];
  exc_code_t m_code [256];
  rob_idx_t  m_idx  [256];
  int        seq_of [`ROB_DEPTH];
  logic      live   [`ROB_DEPTH];
  int        exp_q[$];
  int        seq_n = 0;
  int        tail_m = 0;
  int        jb_cnt = 0;

  int          commits = 0;
  int          mis_pulses = 0;
  int          errors = 0;
  int          checks = 0;
  logic [31:0] rng_state = 32'h66a40293;

  commit_stage dut0 (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Watchdog sized from the test budget
  initial begin
    #((NUM_TESTS * 200 + RST_CYCLES) * 10);
    $display("Timeout: the tests did not finish within the cycle budget");
    $display("sim failed");
    $finish;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Trap target is base times four plus four per cause in vectored mode
  function automatic xlen_t expect_trap_pc(input mtvec_t mt, input exc_code_t code);
    xlen_t pc;
    pc = xlen_t'(mt.base) * 4;
    if (mt.mode) pc = pc + xlen_t'(code) * 4;
    return pc;
  endfunction

  // Expected operand from the model with the CDB ahead of occupied ROB slots
  function automatic operand_t expect_opnd(input rob_idx_t idx);
    operand_t o;
    int       s;
    o.ready = 1'b0;
    o.value = '0;
    if (cdb_valid_i && (cdb_data_i.rob_idx == idx)) begin
      o.ready = 1'b1;
      o.value = cdb_data_i.res_value;
    end else if (live[idx]) begin
      s = seq_of[idx];
      o.ready = m_done[s];
      o.value = m_val[s];
    end
    return o;
  endfunction

  task automatic report_fail(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    errors++;
  endtask

  task automatic clear_model();
    exp_q.delete();
    tail_m = 0;
    jb_cnt = 0;
    for (int i = 0; i < `ROB_DEPTH; i++) live[i] = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Compare process
  // --------------------------------------------------------------------------
  always @(negedge clk_i) begin : compare
    int s;
    if (rst_n_i) begin
      if (int_rf_valid_o) begin
        checks++;
        if (exp_q.size() == 0) begin
          report_fail("commit with no instruction pending");
        end else begin
          s = exp_q.pop_front();
          if (rd_idx_o !== m_rd[s] || rd_value_o !== m_val[s])
            report_fail($sformatf("rd x%0d=%h, expected x%0d=%h",
                                  rd_idx_o, rd_value_o, m_rd[s], m_val[s]));
          if (m_exc[s] && !m_mis[s])
            report_fail("trapping instruction wrote rd");
          if (ex_mis_flush_o !== m_mis[s])
            report_fail($sformatf("ex_mis_flush_o=%b, expected %b", ex_mis_flush_o, m_mis[s]));
          if (m_jb[s]) jb_cnt--;
          live[m_idx[s]] = 1'b0;
          commits++;
        end
      end
      if (fe_except_raised_o) begin
        checks++;
        if (exp_q.size() == 0) begin
          report_fail("trap raised with no instruction pending");
        end else begin
          s = exp_q[0];
          if (fe_except_pc_o !== expect_trap_pc(mtvec_i, m_code[s]))
            report_fail($sformatf("trap pc %h, expected %h", fe_except_pc_o,
                                  expect_trap_pc(mtvec_i, m_code[s])));
          if (!except_flush_o) report_fail("except_flush_o low during trap");
        end
      end
      if (ex_mis_flush_o) mis_pulses++;
      checks++;
      if (sb_spec_instr_o !== (jb_cnt != 0))
        report_fail($sformatf("sb_spec_instr_o=%b with %0d branches in flight",
                              sb_spec_instr_o, jb_cnt));
      // Flush lands at the next edge
      if (ex_mis_flush_o || (fe_except_raised_o && fe_ready_i)) clear_model();
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------------------------------
  task automatic issue_instr(input reg_idx_t rd, input logic jb, output rob_idx_t idx);
    int s;
    @(negedge clk_i);
    if (!issue_ready_o) report_fail("issue_ready_o low on a free ROB");
    checks++;
    if (issue_tail_idx_o !== rob_idx_t'(tail_m))
      report_fail($sformatf("issue_tail_idx_o=%0d, expected %0d", issue_tail_idx_o, tail_m));
    @(posedge clk_i);
    issue_valid_i    <= 1'b1;
    issue_jb_instr_i <= jb;
    issue_data_i     <= '{instr_pc: next_rand(), rd_idx: rd, jb_instr: jb};
    @(posedge clk_i);
    issue_valid_i    <= 1'b0;
    issue_jb_instr_i <= 1'b0;
    s = seq_n;
    seq_n++;
    idx = rob_idx_t'(tail_m);
    m_rd[s] = rd;
    m_jb[s] = jb;
    m_done[s] = 1'b0;
    m_exc[s] = 1'b0;
    m_mis[s] = 1'b0;
    m_idx[s] = idx;
    seq_of[idx] = s;
    live[idx] = 1'b1;
    tail_m = (tail_m + 1) % `ROB_DEPTH;
    exp_q.push_back(s);
    if (jb) jb_cnt++;
  endtask

  task automatic set_result(input rob_idx_t idx, input xlen_t val, input logic exc,
                            input exc_code_t code);
    int s;
    s = seq_of[idx];
    m_val[s] = val;
    m_done[s] = 1'b1;
    m_exc[s] = exc;
    m_code[s] = code;
    m_mis[s] = exc && (code == `EXC_MISPREDICT);
  endtask

  task automatic cdb_write(input rob_idx_t idx, input xlen_t val, input logic exc,
                           input exc_code_t code);
    @(posedge clk_i);
    cdb_valid_i <= 1'b1;
    cdb_data_i  <= '{rob_idx: idx, res_value: val, except_raised: exc, except_code: code};
    set_result(idx, val, exc, code);
    @(posedge clk_i);
    cdb_valid_i <= 1'b0;
  endtask

  task automatic compare_opnd(input string name, input operand_t got, input operand_t exp);
    checks++;
    if (got.ready !== exp.ready || (exp.ready && got.value !== exp.value))
      report_fail($sformatf("%s ready=%b value=%h, expected ready=%b value=%h",
                            name, got.ready, got.value, exp.ready, exp.value));
  endtask

  task automatic check_fwd(input rob_idx_t a, input rob_idx_t b);
    @(posedge clk_i);
    issue_rs1_idx_i <= a;
    issue_rs2_idx_i <= b;
    @(negedge clk_i);
    compare_opnd("rs1", issue_rs1_o, expect_opnd(a));
    compare_opnd("rs2", issue_rs2_o, expect_opnd(b));
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("Instructions still pending after 100 cycles at %0t", $time);
      errors++;
    end
    repeat (2) @(negedge clk_i);
  endtask

  task automatic end_test(input string name, input int err_before);
    $display("test %-14s %s", name, (errors == err_before) ? "ok" : "errors");
  endtask

  task automatic write_shuffled(input rob_idx_t ids[$]);
    int       j;
    rob_idx_t t;
    for (int i = ids.size() - 1; i > 0; i--) begin
      j = int'(next_rand() % (i + 1));
      t = ids[i];
      ids[i] = ids[j];
      ids[j] = t;
    end
    foreach (ids[i]) cdb_write(ids[i], next_rand(), 1'b0, '0);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    rob_idx_t  ids[$];
    rob_idx_t  idx;
    int        e0;
    int        c0;
    int        n;
    exc_code_t code;
    operand_t  slot_op;

    rst_n_i = 1'b0;
    issue_valid_i = 1'b0;
    issue_data_i = '0;
    issue_jb_instr_i = 1'b0;
    issue_rs1_idx_i = '0;
    issue_rs2_idx_i = '0;
    cdb_valid_i = 1'b0;
    cdb_data_i = '0;
    mtvec_i = '0;
    fe_ready_i = 1'b0;
    clear_model();
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // In-order commit with out-of-order writeback
    e0 = errors;
    ids.delete();
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      issue_instr(reg_idx_t'(next_rand()), 1'b0, idx);
      ids.push_back(idx);
    end
    write_shuffled(ids);
    wait_drain();
    end_test("commit_order", e0);

    // Operand forwarding with the head left unwritten so nothing commits
    e0 = errors;
    ids.delete();
    for (int i = 0; i < 4; i++) begin
      issue_instr(reg_idx_t'(next_rand()), 1'b0, idx);
      ids.push_back(idx);
    end
    cdb_write(ids[1], next_rand(), 1'b0, '0);
    cdb_write(ids[3], next_rand(), 1'b0, '0);
    for (int i = 0; i < `ROB_DEPTH; i++) check_fwd(rob_idx_t'(i), rob_idx_t'(7 - i));
    // CDB beats the ROB in the same cycle
    @(posedge clk_i);
    cdb_valid_i     <= 1'b1;
    cdb_data_i      <= '{rob_idx: ids[0], res_value: next_rand(), except_raised: 1'b0,
                         except_code: '0};
    issue_rs1_idx_i <= ids[0];
    issue_rs2_idx_i <= ids[2];
    @(negedge clk_i);
    compare_opnd("rs1 cdb", issue_rs1_o, expect_opnd(ids[0]));
    compare_opnd("rs2 rob", issue_rs2_o, expect_opnd(ids[2]));
    set_result(ids[0], cdb_data_i.res_value, 1'b0, '0);
    @(posedge clk_i);
    cdb_valid_i <= 1'b0;
    // Head pops at the next edge and then forwards from the commit slot
    repeat (2) @(negedge clk_i);
    slot_op.ready = 1'b1;
    slot_op.value = m_val[seq_of[ids[0]]];
    compare_opnd("rs1 slot", issue_rs1_o, slot_op);
    compare_opnd("rs2 rob", issue_rs2_o, expect_opnd(ids[2]));
    cdb_write(ids[2], next_rand(), 1'b0, '0);
    wait_drain();
    end_test("forwarding", e0);

    // Misprediction on the oldest jump
    e0 = errors;
    c0 = commits;
    n = mis_pulses;
    ids.delete();
    issue_instr(5'd3, 1'b1, idx);
    ids.push_back(idx);
    issue_instr(5'd4, 1'b1, idx);
    ids.push_back(idx);
    issue_instr(5'd5, 1'b0, idx);
    ids.push_back(idx);
    cdb_write(ids[2], next_rand(), 1'b0, '0);
    cdb_write(ids[1], next_rand(), 1'b0, '0);
    cdb_write(ids[0], next_rand(), 1'b1, `EXC_MISPREDICT);
    wait_drain();
    repeat (4) @(negedge clk_i);
    checks++;
    if (commits - c0 != 1 || mis_pulses - n != 1 || !issue_ready_o || sb_spec_instr_o)
      report_fail($sformatf("after mispredict commits=%0d pulses=%0d ready=%b spec=%b",
                            commits - c0, mis_pulses - n, issue_ready_o, sb_spec_instr_o));
    end_test("mispredict", e0);

    // Trap in direct and then vectored mode
    e0 = errors;
    for (int mode = 0; mode < 2; mode++) begin
      c0 = commits;
      code = exc_code_t'(next_rand() % 14);
      @(posedge clk_i);
      mtvec_i <= '{base: (`XLEN-2)'(next_rand()), mode: mode[0]};
      ids.delete();
      for (int i = 0; i < 3; i++) begin
        issue_instr(reg_idx_t'(next_rand()), 1'b0, idx);
        ids.push_back(idx);
      end
      cdb_write(ids[1], next_rand(), 1'b1, code);
      cdb_write(ids[2], next_rand(), 1'b0, '0);
      cdb_write(ids[0], next_rand(), 1'b0, '0);
      n = 0;
      while (!fe_except_raised_o && n < 50) begin
        @(negedge clk_i);
        n++;
      end
      if (!fe_except_raised_o) report_fail("trap never raised");
      repeat (3) @(negedge clk_i);
      checks++;
      if (!fe_except_raised_o) report_fail("trap dropped before fe_ready_i");
      @(posedge clk_i);
      fe_ready_i <= 1'b1;
      @(posedge clk_i);
      fe_ready_i <= 1'b0;
      wait_drain();
      repeat (3) @(negedge clk_i);
      checks++;
      if (commits - c0 != 1 || fe_except_raised_o || !issue_ready_o)
        report_fail($sformatf("after trap commits=%0d raised=%b ready=%b",
                              commits - c0, fe_except_raised_o, issue_ready_o));
    end
    end_test("exception", e0);

    // Speculative flag over a random jump/branch mix
    e0 = errors;
    ids.delete();
    for (int i = 0; i < 6; i++) begin
      issue_instr(reg_idx_t'(next_rand()), next_rand() % 2 == 0, idx);
      ids.push_back(idx);
    end
    write_shuffled(ids);
    wait_drain();
    end_test("spec_flag", e0);

    // Back-pressure with a full ROB
    e0 = errors;
    ids.delete();
    for (int i = 0; i < `ROB_DEPTH; i++) begin
      issue_instr(reg_idx_t'(next_rand()), 1'b0, idx);
      ids.push_back(idx);
    end
    @(negedge clk_i);
    checks++;
    if (issue_ready_o) report_fail("issue_ready_o high on a full ROB");
    c0 = commits;
    cdb_write(ids[0], next_rand(), 1'b0, '0);
    n = 0;
    while (commits == c0 && n < 20) begin
      @(negedge clk_i);
      n++;
    end
    checks++;
    if (!issue_ready_o) report_fail("issue_ready_o still low after the first commit");
    ids.pop_front();
    write_shuffled(ids);
    wait_drain();
    end_test("backpressure", e0);

    $display("tests %0d, checks %0d, commits %0d, errors %0d",
             NUM_TESTS, checks, commits, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+common
common/commit_pkg.sv
rob/rob.sv
source/commit_fsm.sv
source/jb_counter.sv
source/commit_slot.sv
source/operand_fwd.sv
source/commit_stage.sv
tests/tb_commit_stage.sv

/* Makefile */
TOOL     ?= verilator
FLAGS    ?= --binary --timing -Wno-fatal
TOP      ?= tb_commit_stage
FILELIST ?= build.f

OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST)) common/commit_cfg.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'sim passed'

clean:
	rm -rf $(OBJ_DIR)
